// ==== hdl/snn_consts.svh ====
/*
 * neuron-state store widths and depths
 * shared by the RTL and the testbench
 */
`ifndef SNN_CONSTS_SVH
`define SNN_CONSTS_SVH

// neuron and axon index widths
`define SNN_NURN_BITS 4
`define SNN_AXON_BITS 4

`define SNN_DSIZE 16
`define SNN_HIST_BITS 8
`define SNN_HIST_MAX 255

// one weight per neuron per step
`define SNN_FIFO_AW `SNN_NURN_BITS

`define SNN_LEAK_BITS 4

`endif

// ==== hdl/snn_pkg.sv ====
/*
 * neuron-state store types
 * host access targets, port bundles and engine states
 */
`include "snn_consts.svh"

package snn_pkg;

	typedef enum logic [2:0] {
		BIAS     = 3'd0,
		POT      = 3'd1,
		TH       = 3'd2,
		HIST     = 3'd3,
		WEIGHT   = 3'd4,
		CFG_NUM  = 3'd5,
		CFG_LEAK = 3'd6
	} mem_target_e;

	typedef struct packed {
		logic                      valid;
		logic                      write;
		mem_target_e               target;
		logic [`SNN_NURN_BITS-1:0] neuron;
		logic [`SNN_AXON_BITS-1:0] axon;
		logic [`SNN_DSIZE-1:0]     data;
	} host_req_t;

	// port B, one write enable per neuron field
	typedef struct packed {
		logic                      bias_we;
		logic                      pot_we;
		logic                      th_we;
		logic                      hist_we;
		logic [`SNN_NURN_BITS-1:0] neuron;
		logic [`SNN_DSIZE-1:0]     data;
	} state_wr_t;

	// port A, sel is bias 0, pot 1, th 2, hist 3
	typedef struct packed {
		logic                      en;
		logic [1:0]                sel;
		logic [`SNN_NURN_BITS-1:0] neuron;
	} state_rd_t;

	// port G
	typedef struct packed {
		logic                      en;
		logic [`SNN_NURN_BITS-1:0] neuron;
		logic [`SNN_AXON_BITS-1:0] axon;
		logic [`SNN_DSIZE-1:0]     data;
	} weight_wr_t;

	typedef struct packed {
		logic                      valid;
		logic [`SNN_NURN_BITS-1:0] neuron;
	} spike_t;

	typedef struct packed {
		logic                      start;
		logic                      axon_valid;
		logic [`SNN_AXON_BITS-1:0] axon;
	} step_t;

	typedef enum logic [2:0] {
		IDLE, PREFETCH, RD_FIELD, CALC, WRITE, DONE
	} upd_state_e;

endpackage

// ==== hdl/weight_fifo.sv ====
/*
 * single-clock weight FIFO
 * popped word is registered and shows up the cycle after the pop
 */
`include "snn_consts.svh"

module weight_fifo #(
	parameter int DW = `SNN_DSIZE,
	parameter int AW = `SNN_FIFO_AW
) (
	input  logic          clk_i,
	input  logic          rst_n_i,
	input  logic          clr_i,
	input  logic          push_i,
	input  logic [DW-1:0] push_data_i,
	input  logic          pop_i,
	output logic [DW-1:0] pop_data_o,
	output logic          full_o,
	output logic          empty_o
);
	logic [DW-1:0] buf_mem [1 << AW];
	logic [AW-1:0] wr_ptr_q;
	logic [AW-1:0] rd_ptr_q;
	logic [AW:0]   level_q;
	logic [DW-1:0] pop_data_q;

	// depth is a power of two, so the top level bit means full
	assign full_o = level_q[AW];
	assign empty_o = (level_q == '0);
	assign pop_data_o = pop_data_q;

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i || clr_i)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			level_q <= '0;
		end
		else
		begin
			if (push_i)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (pop_i)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			if (push_i && !pop_i)
				level_q <= level_q + 1'b1;
			else if (pop_i && !push_i)
				level_q <= level_q - 1'b1;
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (push_i)
			buf_mem[wr_ptr_q] <= push_data_i;
		if (pop_i)
			pop_data_q <= buf_mem[rd_ptr_q];
	end

	// prefetch never runs ahead of the depth, and pops follow pushes
	a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(push_i && full_o)) else $error("weight fifo push while full");
	a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(pop_i && empty_o)) else $error("weight fifo pop while empty");

endmodule

// ==== hdl/status_mem.sv ====
/*
 * status memory of one core
 * bias, potential, threshold and history arrays on shared ports A and B,
 * weight array on ports E and G with prefetched words buffered for port F
 */
`include "snn_consts.svh"

module status_mem (
	input  logic                      clk_i,
	input  logic                      rst_n_i,
	input  logic                      clr_i,
	input  snn_pkg::state_rd_t        rd_a_i,
	output logic [`SNN_DSIZE-1:0]     rd_a_data_o,
	input  snn_pkg::state_wr_t        wr_b_i,
	input  logic                      rd_e_en_i,
	input  logic [`SNN_NURN_BITS-1:0] rd_e_neuron_i,
	input  logic [`SNN_AXON_BITS-1:0] rd_e_axon_i,
	output logic [`SNN_DSIZE-1:0]     rd_e_data_o,
	input  snn_pkg::weight_wr_t       wr_g_i,
	input  logic                      rd_f_en_i,
	output logic [`SNN_DSIZE-1:0]     rd_f_data_o,
	output logic                      fifo_empty_o
);
	localparam int DW = `SNN_DSIZE;
	localparam int NURNS = 1 << `SNN_NURN_BITS;
	localparam int WA = `SNN_NURN_BITS + `SNN_AXON_BITS;

	logic [3:0]    fld_we;
	logic [DW-1:0] fld_rdata [4];
	logic [1:0]    sel_q;
	logic [DW-1:0] weight_mem [1 << WA];
	logic [WA-1:0] weight_addr_q;
	logic          fifo_push_q;

	// field order matches the port-A select code
	assign fld_we = {wr_b_i.hist_we, wr_b_i.th_we, wr_b_i.pot_we, wr_b_i.bias_we};

	for (genvar f = 0; f < 4; f++)
	begin : g_field
		// history is the only narrow field
		localparam int W = (f == 3) ? `SNN_HIST_BITS : DW;

		logic [W-1:0]               mem [NURNS];
		logic [`SNN_NURN_BITS-1:0] addr_q;

		always_ff @(posedge clk_i)
		begin
			if (rd_a_i.en && rd_a_i.sel == 2'(f))
				addr_q <= rd_a_i.neuron;
			if (fld_we[f])
				mem[wr_b_i.neuron] <= wr_b_i.data[W-1:0];
		end

		assign fld_rdata[f] = DW'(mem[addr_q]);
	end

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
			sel_q <= '0;
		else if (rd_a_i.en)
			sel_q <= rd_a_i.sel;
	end

	assign rd_a_data_o = fld_rdata[sel_q];

	// weights addressed as {neuron, axon}
	always_ff @(posedge clk_i)
	begin
		if (rd_e_en_i)
			weight_addr_q <= {rd_e_neuron_i, rd_e_axon_i};
		if (wr_g_i.en)
			weight_mem[{wr_g_i.neuron, wr_g_i.axon}] <= wr_g_i.data;
	end

	assign rd_e_data_o = weight_mem[weight_addr_q];

	// the word read on port E lands in the fifo one cycle later
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
			fifo_push_q <= 1'b0;
		else
			fifo_push_q <= rd_e_en_i;
	end

	weight_fifo #(
		.DW(DW),
		.AW(`SNN_FIFO_AW)
	) weight_fifo_i (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.clr_i      (clr_i),
		.push_i     (fifo_push_q),
		.push_data_i(rd_e_data_o),
		.pop_i      (rd_f_en_i),
		.pop_data_o (rd_f_data_o),
		.full_o     (),
		.empty_o    (fifo_empty_o)
	);

endmodule

// ==== hdl/core_cfg_regs.sv ====
/*
 * core configuration registers
 * active neuron count and leak shift, written by the host
 */
`include "snn_consts.svh"

module core_cfg_regs (
	input  logic                      clk_i,
	input  logic                      rst_n_i,
	input  snn_pkg::host_req_t        host_req_i,
	output logic [`SNN_NURN_BITS:0]   num_neurons_o,
	output logic [`SNN_LEAK_BITS-1:0] leak_shift_o
);
	import snn_pkg::*;

	localparam int NB = `SNN_NURN_BITS + 1;
	localparam int MAX_NURNS = 1 << `SNN_NURN_BITS;
	localparam int LEAK_RST = 4;

	logic          num_wr;
	logic          leak_wr;
	logic [NB-1:0] num_next;

	assign num_wr = host_req_i.valid && host_req_i.write && host_req_i.target == CFG_NUM;
	assign leak_wr = host_req_i.valid && host_req_i.write && host_req_i.target == CFG_LEAK;

	// zero becomes one, anything past the array becomes the full count
	always_comb
	begin
		if (host_req_i.data == '0)
			num_next = NB'(1);
		else if (int'(host_req_i.data) > MAX_NURNS)
			num_next = NB'(MAX_NURNS);
		else
			num_next = host_req_i.data[NB-1:0];
	end

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			num_neurons_o <= NB'(MAX_NURNS);
			leak_shift_o <= `SNN_LEAK_BITS'(LEAK_RST);
		end
		else
		begin
			if (num_wr)
				num_neurons_o <= num_next;
			if (leak_wr)
				leak_shift_o <= host_req_i.data[`SNN_LEAK_BITS-1:0];
		end
	end

	a_num_nonzero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		num_wr |-> host_req_i.data != '0) else $error("neuron count written as zero");

endmodule

// ==== hdl/neuron_update.sv ====
/*
 * neuron update engine
 * one leaky integrate-and-fire step per start pulse, weights prefetched
 * into the fifo first, then each active neuron read, updated and written back
 */
`include "snn_consts.svh"

module neuron_update (
	input  logic                      clk_i,
	input  logic                      rst_n_i,
	input  snn_pkg::step_t            step_i,
	input  logic [`SNN_NURN_BITS:0]   num_neurons_i,
	input  logic [`SNN_LEAK_BITS-1:0] leak_shift_i,
	output snn_pkg::state_rd_t        rd_a_o,
	input  logic [`SNN_DSIZE-1:0]     rd_a_data_i,
	output snn_pkg::state_wr_t        wr_b_o,
	output logic                      rd_e_en_o,
	output logic [`SNN_NURN_BITS-1:0] rd_e_neuron_o,
	output logic [`SNN_AXON_BITS-1:0] rd_e_axon_o,
	output logic                      rd_f_en_o,
	input  logic [`SNN_DSIZE-1:0]     rd_f_data_i,
	output snn_pkg::spike_t           spike_o,
	output logic                      busy_o,
	output logic                      done_o
);
	import snn_pkg::*;

	localparam int DW = `SNN_DSIZE;
	localparam int HB = `SNN_HIST_BITS;

	upd_state_e                state_q;
	logic [`SNN_NURN_BITS-1:0] nrn_q;
	logic [1:0]                sub_q;
	logic                      axon_valid_q;
	logic [`SNN_AXON_BITS-1:0] axon_q;
	logic                      last_nrn;
	logic                      rd_pend_q;
	logic [1:0]                rd_sel_q;
	logic signed [DW-1:0]      bias_q, pot_q, th_q;
	logic signed [DW-1:0]      weight, leak, new_pot;
	logic signed [DW+1:0]      sum;
	logic [HB-1:0]             hist_now, new_hist;
	logic                      fire;
	logic signed [DW-1:0]      new_pot_q;
	logic [HB-1:0]             new_hist_q;
	spike_t                    spike_q;

	assign last_nrn = ({1'b0, nrn_q} == num_neurons_i - 1'b1);

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			state_q <= IDLE;
			nrn_q <= '0;
			sub_q <= '0;
			axon_valid_q <= 1'b0;
			axon_q <= '0;
		end
		else
		begin
			case (state_q)
				IDLE:
					if (step_i.start)
					begin
						axon_valid_q <= step_i.axon_valid;
						axon_q <= step_i.axon;
						nrn_q <= '0;
						sub_q <= '0;
						state_q <= step_i.axon_valid ? PREFETCH : RD_FIELD;
					end
				// one weight read per active neuron, back to back
				PREFETCH:
				begin
					nrn_q <= last_nrn ? '0 : nrn_q + 1'b1;
					if (last_nrn)
						state_q <= RD_FIELD;
				end
				RD_FIELD:
				begin
					sub_q <= sub_q + 1'b1;
					if (sub_q == 2'd3)
						state_q <= CALC;
				end
				CALC:
					state_q <= WRITE;
				// potential on sub 0, history on sub 1
				WRITE:
				begin
					sub_q <= sub_q + 1'b1;
					if (sub_q == 2'd1)
					begin
						sub_q <= '0;
						nrn_q <= nrn_q + 1'b1;
						state_q <= last_nrn ? DONE : RD_FIELD;
					end
				end
				default:
					state_q <= IDLE;
			endcase
		end
	end

	// fields come back one cycle after their read
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			rd_pend_q <= 1'b0;
			rd_sel_q <= '0;
		end
		else
		begin
			rd_pend_q <= rd_a_o.en;
			rd_sel_q <= rd_a_o.sel;
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (rd_pend_q && rd_sel_q == 2'd0)
			bias_q <= rd_a_data_i;
		if (rd_pend_q && rd_sel_q == 2'd1)
			pot_q <= rd_a_data_i;
		if (rd_pend_q && rd_sel_q == 2'd2)
			th_q <= rd_a_data_i;
		if (state_q == CALC)
		begin
			new_pot_q <= fire ? '0 : new_pot;
			new_hist_q <= new_hist;
		end
	end

	// history is used straight off port A in CALC
	always_comb
	begin
		weight = axon_valid_q ? rd_f_data_i : '0;
		leak = pot_q >>> leak_shift_i;
		sum = pot_q - leak + bias_q + weight;
		// saturate to the signed data range
		if (sum[DW+1:DW-1] == '0 || sum[DW+1:DW-1] == '1)
			new_pot = sum[DW-1:0];
		else if (sum[DW+1])
			new_pot = {1'b1, {(DW-1){1'b0}}};
		else
			new_pot = {1'b0, {(DW-1){1'b1}}};
		fire = (new_pot >= th_q);
		hist_now = rd_a_data_i[HB-1:0];
		if (fire)
			new_hist = HB'(`SNN_HIST_MAX);
		else if (hist_now == '0)
			new_hist = '0;
		else
			new_hist = hist_now - 1'b1;
	end

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
			spike_q <= '0;
		else
		begin
			spike_q.valid <= (state_q == CALC) && fire;
			spike_q.neuron <= nrn_q;
		end
	end

	assign rd_a_o.en = (state_q == RD_FIELD);
	assign rd_a_o.sel = sub_q;
	assign rd_a_o.neuron = nrn_q;

	assign rd_e_en_o = (state_q == PREFETCH);
	assign rd_e_neuron_o = nrn_q;
	assign rd_e_axon_o = axon_q;

	// pop with the history read so the weight is ready in CALC
	assign rd_f_en_o = (state_q == RD_FIELD) && (sub_q == 2'd3) && axon_valid_q;

	assign wr_b_o.bias_we = 1'b0;
	assign wr_b_o.th_we = 1'b0;
	assign wr_b_o.pot_we = (state_q == WRITE) && (sub_q == 2'd0);
	assign wr_b_o.hist_we = (state_q == WRITE) && (sub_q == 2'd1);
	assign wr_b_o.neuron = nrn_q;
	assign wr_b_o.data = (sub_q == 2'd0) ? new_pot_q : DW'(new_hist_q);

	assign spike_o = spike_q;
	assign busy_o = (state_q != IDLE);
	assign done_o = (state_q == DONE);

	a_read_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		state_q == CALC |-> rd_pend_q && rd_sel_q == 2'd3 && (!axon_valid_q || $past(rd_f_en_o)))
		else $error("history or weight consumed before its read latency");

endmodule

// ==== hdl/snn_core_top.sv ====
/*
 * neuron-state store of one core
 * host access while idle, update engine while busy
 */
`include "snn_consts.svh"

module snn_core_top (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  snn_pkg::host_req_t    host_req_i,
	input  snn_pkg::step_t        step_i,
	output logic [`SNN_DSIZE-1:0] host_rd_data_o,
	output logic                  host_rd_valid_o,
	output snn_pkg::spike_t       spike_o,
	output logic                  busy_o,
	output logic                  done_o
);
	import snn_pkg::*;

	localparam int DW = `SNN_DSIZE;

	logic                      host_rd, host_wr;
	state_rd_t                 host_rd_a, upd_rd_a, rd_a;
	state_wr_t                 host_wr_b, upd_wr_b, wr_b;
	weight_wr_t                host_wr_g, wr_g;
	logic                      upd_rd_e_en, rd_e_en;
	logic [`SNN_NURN_BITS-1:0] upd_rd_e_neuron, rd_e_neuron;
	logic [`SNN_AXON_BITS-1:0] upd_rd_e_axon, rd_e_axon;
	logic                      rd_f_en, fifo_empty;
	logic [DW-1:0]             rd_a_data, rd_e_data, rd_f_data;
	logic [`SNN_NURN_BITS:0]   num_neurons;
	logic [`SNN_LEAK_BITS-1:0] leak_shift;
	logic                      rd_valid_q;
	mem_target_e               rd_tgt_q;

	assign host_rd = host_req_i.valid && !host_req_i.write;
	assign host_wr = host_req_i.valid && host_req_i.write;

	// the four field targets share their code with the port-A select
	assign host_rd_a.en = host_rd && (host_req_i.target inside {BIAS, POT, TH, HIST});
	assign host_rd_a.sel = 2'(host_req_i.target);
	assign host_rd_a.neuron = host_req_i.neuron;

	assign host_wr_b.bias_we = host_wr && host_req_i.target == BIAS;
	assign host_wr_b.pot_we = host_wr && host_req_i.target == POT;
	assign host_wr_b.th_we = host_wr && host_req_i.target == TH;
	assign host_wr_b.hist_we = host_wr && host_req_i.target == HIST;
	assign host_wr_b.neuron = host_req_i.neuron;
	assign host_wr_b.data = host_req_i.data;

	assign host_wr_g.en = host_wr && host_req_i.target == WEIGHT;
	assign host_wr_g.neuron = host_req_i.neuron;
	assign host_wr_g.axon = host_req_i.axon;
	assign host_wr_g.data = host_req_i.data;

	// the engine owns the ports while busy and never writes weights
	assign rd_a = busy_o ? upd_rd_a : host_rd_a;
	assign wr_b = busy_o ? upd_wr_b : host_wr_b;
	assign wr_g = busy_o ? '0 : host_wr_g;
	assign rd_e_en = busy_o ? upd_rd_e_en : host_rd && host_req_i.target == WEIGHT;
	assign rd_e_neuron = busy_o ? upd_rd_e_neuron : host_req_i.neuron;
	assign rd_e_axon = busy_o ? upd_rd_e_axon : host_req_i.axon;

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			rd_valid_q <= 1'b0;
			rd_tgt_q <= BIAS;
		end
		else
		begin
			rd_valid_q <= host_rd;
			rd_tgt_q <= host_req_i.target;
		end
	end

	always_comb
	begin
		case (rd_tgt_q)
			WEIGHT:   host_rd_data_o = rd_e_data;
			CFG_NUM:  host_rd_data_o = DW'(num_neurons);
			CFG_LEAK: host_rd_data_o = DW'(leak_shift);
			default:  host_rd_data_o = rd_a_data;
		endcase
	end

	assign host_rd_valid_o = rd_valid_q;

	// fifo held clear while idle, which also drops words pushed by host weight reads
	status_mem status_mem_i (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .clr_i(!busy_o),
		.rd_a_i(rd_a), .rd_a_data_o(rd_a_data), .wr_b_i(wr_b),
		.rd_e_en_i(rd_e_en), .rd_e_neuron_i(rd_e_neuron), .rd_e_axon_i(rd_e_axon),
		.rd_e_data_o(rd_e_data), .wr_g_i(wr_g),
		.rd_f_en_i(rd_f_en), .rd_f_data_o(rd_f_data), .fifo_empty_o(fifo_empty)
	);

	core_cfg_regs core_cfg_regs_i (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .host_req_i(host_req_i),
		.num_neurons_o(num_neurons), .leak_shift_o(leak_shift)
	);

	neuron_update neuron_update_i (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .step_i(step_i),
		.num_neurons_i(num_neurons), .leak_shift_i(leak_shift),
		.rd_a_o(upd_rd_a), .rd_a_data_i(rd_a_data), .wr_b_o(upd_wr_b),
		.rd_e_en_o(upd_rd_e_en), .rd_e_neuron_o(upd_rd_e_neuron), .rd_e_axon_o(upd_rd_e_axon),
		.rd_f_en_o(rd_f_en), .rd_f_data_i(rd_f_data),
		.spike_o(spike_o), .busy_o(busy_o), .done_o(done_o)
	);

	a_host_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		busy_o |-> !host_req_i.valid) else $error("host request while engine busy");

	// every prefetched weight is consumed by the end of the step
	a_fifo_drained: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		done_o |-> fifo_empty) else $error("weights left in fifo at end of step");

endmodule

// ==== sim/snn_core_tb.sv ====
/*
 * testbench for the neuron-state store of one core
 * loads and reads back every array, then runs update steps against a shadow model
 */
`include "snn_consts.svh"

module snn_core_tb;
	import snn_pkg::*;

	localparam int NURNS = 1 << `SNN_NURN_BITS;
	localparam int AXONS = 1 << `SNN_AXON_BITS;
	localparam int DW = `SNN_DSIZE;
	localparam int HB = `SNN_HIST_BITS;
	localparam int NUM_STEPS = 13;
	// host loads and readbacks of the whole run stay below this
	localparam int LOAD_CYCLES = 1500;
	localparam int TIMEOUT_CYCLES = 2000 * NUM_STEPS + LOAD_CYCLES;

	typedef struct packed {
		logic          fire;
		logic [DW-1:0] pot;
		logic [HB-1:0] hist;
	} upd_res_t;

	typedef struct packed {
		mem_target_e               target;
		logic [`SNN_NURN_BITS-1:0] neuron;
		logic [DW-1:0]             data;
		int                        due;
	} rd_exp_t;

	logic          clk;
	logic          rst_n;
	host_req_t     host_req;
	step_t         step;
	logic [DW-1:0] rd_data;
	logic          rd_valid;
	spike_t        spike;
	logic          busy;
	logic          done;

	// shadow copy of the status memory and config
	logic signed [DW-1:0] bias_sh [NURNS];
	logic signed [DW-1:0] pot_sh [NURNS];
	logic signed [DW-1:0] th_sh [NURNS];
	logic [HB-1:0]        hist_sh [NURNS];
	logic signed [DW-1:0] w_sh [NURNS][AXONS];
	int                   num_sh = NURNS;
	int                   leak_sh = 4;

	rd_exp_t                   rd_exp_q [$];
	logic [`SNN_NURN_BITS-1:0] spike_exp_q [$];
	rd_exp_t                   rd_head;
	mem_target_e               rd_tgt;
	logic [`SNN_NURN_BITS-1:0] spike_head;
	int                        check_cnt = 0;
	int                        error_cnt = 0;
	int                        cycle_cnt = 0;

	snn_core_top dut_i (
		.clk_i          (clk),
		.rst_n_i        (rst_n),
		.host_req_i     (host_req),
		.step_i         (step),
		.host_rd_data_o (rd_data),
		.host_rd_valid_o(rd_valid),
		.spike_o        (spike),
		.busy_o         (busy),
		.done_o         (done)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// leaky integrate-and-fire rule with the potential saturated to the signed word
	function automatic upd_res_t neuron_ref(input int pot, input int bias, input int th,
		input int hist, input int weight, input int leak);
		upd_res_t res;
		int       sum;
		sum = pot - (pot >>> leak) + bias + weight;
		if (sum > 32767)
			sum = 32767;
		else if (sum < -32768)
			sum = -32768;
		res.fire = (sum >= th);
		if (res.fire)
		begin
			res.pot = '0;
			res.hist = HB'(`SNN_HIST_MAX);
		end
		else
		begin
			res.pot = sum[DW-1:0];
			res.hist = (hist == 0) ? '0 : HB'(hist - 1);
		end
		return res;
	endfunction

	function automatic logic [DW-1:0] shadow_value(input mem_target_e tgt, input int nrn,
		input int axn);
		case (tgt)
			BIAS:     return bias_sh[nrn];
			POT:      return pot_sh[nrn];
			TH:       return th_sh[nrn];
			HIST:     return DW'(hist_sh[nrn]);
			WEIGHT:   return w_sh[nrn][axn];
			CFG_NUM:  return DW'(num_sh);
			CFG_LEAK: return DW'(leak_sh);
			default:  return '0;
		endcase
	endfunction

	task automatic host_write(input mem_target_e tgt, input int nrn, input int axn,
		input logic [DW-1:0] data);
		host_req.valid = 1'b1;
		host_req.write = 1'b1;
		host_req.target = tgt;
		host_req.neuron = nrn[`SNN_NURN_BITS-1:0];
		host_req.axon = axn[`SNN_AXON_BITS-1:0];
		host_req.data = data;
		case (tgt)
			BIAS:     bias_sh[nrn] = data;
			POT:      pot_sh[nrn] = data;
			TH:       th_sh[nrn] = data;
			HIST:     hist_sh[nrn] = data[HB-1:0];
			WEIGHT:   w_sh[nrn][axn] = data;
			// zero count reads back as one and big counts clip to the array
			CFG_NUM:  num_sh = (data == '0) ? 1 : (int'(data) > NURNS) ? NURNS : int'(data);
			CFG_LEAK: leak_sh = int'(data[`SNN_LEAK_BITS-1:0]);
			default:  ;
		endcase
		@(posedge clk);
		#2;
		host_req = '0;
	endtask

	task automatic host_read(input mem_target_e tgt, input int nrn, input int axn);
		rd_exp_t e;
		e.target = tgt;
		e.neuron = nrn[`SNN_NURN_BITS-1:0];
		e.data = shadow_value(tgt, nrn, axn);
		// data is due in the cycle after the edge that takes the request
		e.due = cycle_cnt + 1;
		rd_exp_q.push_back(e);
		host_req.valid = 1'b1;
		host_req.write = 1'b0;
		host_req.target = tgt;
		host_req.neuron = nrn[`SNN_NURN_BITS-1:0];
		host_req.axon = axn[`SNN_AXON_BITS-1:0];
		host_req.data = '0;
		@(posedge clk);
		#2;
		host_req = '0;
	endtask

	task automatic load_state();
		int n;
		int a;
		for (n = 0; n < NURNS; n++)
		begin
			host_write(BIAS, n, 0, DW'($urandom_range(0, 200) - 60));
			host_write(POT, n, 0, DW'($urandom_range(0, 300)));
			host_write(TH, n, 0, DW'($urandom_range(100, 600)));
			// low history so decay hits zero within a few steps
			host_write(HIST, n, 0, DW'($urandom_range(0, 3)));
			for (a = 0; a < AXONS; a++)
				host_write(WEIGHT, n, a, DW'($urandom_range(0, 400)));
		end
	endtask

	task automatic read_state();
		int n;
		for (n = 0; n < NURNS; n++)
		begin
			host_read(POT, n, 0);
			host_read(HIST, n, 0);
		end
	endtask

	task automatic run_step(input logic axon_valid, input int axon);
		upd_res_t res;
		int       n;
		int       w;
		// expected spikes and new state before the DUT starts
		for (n = 0; n < num_sh; n++)
		begin
			w = axon_valid ? int'(w_sh[n][axon]) : 0;
			res = neuron_ref(pot_sh[n], bias_sh[n], th_sh[n], hist_sh[n], w, leak_sh);
			if (res.fire)
				spike_exp_q.push_back(n[`SNN_NURN_BITS-1:0]);
			pot_sh[n] = res.pot;
			hist_sh[n] = res.hist;
		end
		@(posedge clk);
		#2;
		step.start = 1'b1;
		step.axon_valid = axon_valid;
		step.axon = axon[`SNN_AXON_BITS-1:0];
		@(posedge clk);
		#2;
		step = '0;
		@(negedge clk);
		check_cnt++;
		if (!busy)
		begin
			$display("busy_o did not rise after the start pulse");
			error_cnt++;
		end
		while (!done)
			@(negedge clk);
		check_cnt++;
		if (spike_exp_q.size() != 0)
		begin
			$display("%0d expected spikes missing when done_o pulsed", spike_exp_q.size());
			error_cnt++;
		end
		@(negedge clk);
		check_cnt++;
		if (done)
		begin
			$display("done_o stayed high for more than one cycle");
			error_cnt++;
		end
		while (busy)
			@(negedge clk);
		@(posedge clk);
		#2;
	endtask

	task automatic finish_run();
		$display("checks: %0d, errors: %0d", check_cnt, error_cnt);
		if (error_cnt == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	endtask

	// read data and spikes are compared mid-cycle
	always @(negedge clk)
	begin
		if (rd_valid)
		begin
			check_cnt++;
			if (rd_exp_q.size() == 0)
			begin
				$display("host_rd_valid_o high with no host read outstanding");
				error_cnt++;
			end
			else
			begin
				rd_head = rd_exp_q.pop_front();
				rd_tgt = rd_head.target;
				if (cycle_cnt != rd_head.due)
				begin
					$display("host read of %s neuron %0d returned in cycle %0d, not %0d",
						rd_tgt.name(), rd_head.neuron, cycle_cnt, rd_head.due);
					error_cnt++;
				end
				if (rd_data !== rd_head.data)
				begin
					$display("mismatch host_rd_data_o (%s neuron %0d): got 0x%h expected 0x%h",
						rd_tgt.name(), rd_head.neuron, rd_data, rd_head.data);
					error_cnt++;
				end
			end
		end
		if (spike.valid)
		begin
			check_cnt++;
			if (spike_exp_q.size() == 0)
			begin
				$display("spike_o fired for neuron %0d with no spike expected", spike.neuron);
				error_cnt++;
			end
			else
			begin
				spike_head = spike_exp_q.pop_front();
				if (spike.neuron !== spike_head)
				begin
					$display("mismatch spike_o.neuron: got 0x%h expected 0x%h",
						spike.neuron, spike_head);
					error_cnt++;
				end
			end
		end
	end

	initial
	begin
		while (cycle_cnt < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
		error_cnt++;
		finish_run();
	end

	initial
	begin
		int i;
		void'($urandom(89811));
		rst_n = 1'b0;
		host_req = '0;
		step = '0;
		repeat (5) @(posedge clk);
		#2;
		rst_n = 1'b1;

		@(negedge clk);
		check_cnt++;
		if (busy || done || spike.valid || rd_valid)
		begin
			$display("outputs not idle after reset");
			error_cnt++;
		end
		@(posedge clk);
		#2;

		// load and read back every target
		load_state();
		for (i = 0; i < NURNS; i++)
		begin
			host_read(BIAS, i, 0);
			host_read(POT, i, 0);
			host_read(TH, i, 0);
			host_read(HIST, i, 0);
		end
		repeat (32)
			host_read(WEIGHT, $urandom_range(0, NURNS - 1), $urandom_range(0, AXONS - 1));
		host_read(CFG_NUM, 0, 0);
		host_read(CFG_LEAK, 0, 0);
		host_write(CFG_LEAK, 0, 0, DW'(3));
		host_read(CFG_LEAK, 0, 0);
		host_write(CFG_NUM, 0, 0, DW'(NURNS));
		host_read(CFG_NUM, 0, 0);

		// leak and bias only, then one input axon
		run_step(1'b0, 0);
		read_state();
		run_step(1'b1, 5);
		read_state();

		for (i = 0; i < 10; i++)
		begin
			if (i % 3 == 2)
				host_write(CFG_LEAK, 0, 0, DW'($urandom_range(1, 5)));
			run_step(1'($urandom_range(0, 1)), $urandom_range(0, AXONS - 1));
			read_state();
		end

		// neurons past the active count stay put
		host_write(CFG_NUM, 0, 0, DW'(5));
		host_read(CFG_NUM, 0, 0);
		run_step(1'b1, $urandom_range(0, AXONS - 1));
		read_state();

		repeat (2) @(posedge clk);
		#2;
		check_cnt++;
		if (rd_exp_q.size() != 0 || spike_exp_q.size() != 0)
		begin
			$display("%0d host reads and %0d spikes never arrived",
				rd_exp_q.size(), spike_exp_q.size());
			error_cnt++;
		end
		finish_run();
	end

endmodule

// ==== snn_core.f ====
+incdir+hdl
hdl/snn_pkg.sv
hdl/weight_fifo.sv
hdl/status_mem.sv
hdl/core_cfg_regs.sv
hdl/neuron_update.sv
hdl/snn_core_top.sv
sim/snn_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the snn core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f snn_core.f \
	--top-module snn_core_tb -o snn_core_sim
./obj_dir/snn_core_sim | tee sim.log

if grep -qx "All checks passed" sim.log; then
	echo "simulation PASSED"
else
	echo "simulation FAILED"
	exit 1
fi
